// File: hdl/mc_pkg.sv
package mc_pkg;

	// Request address layout, row on top, column at the bottom
	localparam int COL_BITS  = 6;  // Column field
	localparam int BANK_BITS = 2;  // Four banks
	localparam int ROW_BITS  = 8;  // Row field
	localparam int ADDR_BITS = ROW_BITS + BANK_BITS + COL_BITS;  // Full request address

	// Opcodes on the command bus
	typedef enum logic [2:0] {
		CMD_NOP = 3'd0,  // Idle bus, cs_n high
		CMD_ACT = 3'd1,  // Open a row
		CMD_PRE = 3'd2,  // Close the open row of a bank
		CMD_WR  = 3'd3,  // Column write
		CMD_RD  = 3'd4   // Column read
	} cmd_e;

	// Scheduler states
	typedef enum logic [2:0] {
		S_IDLE     = 3'd0,  // Waiting for a head request
		S_PRE      = 3'd1,  // PRE on the bus
		S_WAIT_RP  = 3'd2,  // Precharge gap
		S_ACT      = 3'd3,  // ACT on the bus
		S_WAIT_RCD = 3'd4,  // Activate gap
		S_ISSUE    = 3'd5   // WR or RD on the bus
	} sched_state_e;

endpackage

// File: hdl/req_if.sv
`timescale 1ns/10ps
interface req_if #(
	parameter int DATA_WIDTH = 16
);
	import mc_pkg::*;

	logic                  head_valid;  // Queue not empty
	logic                  head_write;  // 1 = write, 0 = read
	logic [ADDR_BITS-1:0]  head_addr;   // Row, bank, column
	logic [DATA_WIDTH-1:0] head_data;   // Write payload
	logic                  pop;         // Drop head on next edge

	modport queue_side (output head_valid, head_write, head_addr, head_data, input pop);
	modport sched_side (input head_valid, head_write, head_addr, output pop);
	modport data_side  (input head_data);

endinterface

// File: hdl/req_queue.sv
`timescale 1ns/10ps
module req_queue #(
	parameter int DATA_WIDTH  = 16,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          in_valid,
	input  logic                          in_request_type,
	input  logic [mc_pkg::ADDR_BITS-1:0]  in_request_address,
	input  logic [DATA_WIDTH-1:0]         in_request_data,
	output logic                          out_busy,
	req_if.queue_side                     rq
);
	import mc_pkg::*;

	localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

	logic                  type_mem [QUEUE_DEPTH];  // Request type per slot
	logic [ADDR_BITS-1:0]  addr_mem [QUEUE_DEPTH];  // Address per slot
	logic [DATA_WIDTH-1:0] data_mem [QUEUE_DEPTH];  // Payload per slot
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [CNT_BITS-1:0]   count;                   // Occupancy
	logic                  push;
	logic                  do_pop;

	// Circular increment, also for depths that are not a power of two
	function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
		return (p == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign out_busy = (count == CNT_BITS'(QUEUE_DEPTH));  // Full
	assign push     = in_valid && !out_busy;              // Accepted strobe
	assign do_pop   = rq.pop && rq.head_valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Idle, or push and pop together
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			type_mem[wr_ptr] <= in_request_type;
			addr_mem[wr_ptr] <= in_request_address;
			data_mem[wr_ptr] <= in_request_data;
		end
	end

	// Head entry, visible the cycle after the push into an empty queue
	assign rq.head_valid = (count != '0);
	assign rq.head_write = type_mem[rd_ptr];
	assign rq.head_addr  = addr_mem[rd_ptr];
	assign rq.head_data  = data_mem[rd_ptr];

endmodule

// File: hdl/cmd_fsm.sv
`timescale 1ns/10ps
module cmd_fsm #(
	parameter int T_RCD = 3,
	parameter int T_RP  = 2
) (
	input  logic                          clk,
	input  logic                          rst_n,
	req_if.sched_side                     rq,
	input  logic                          hit,
	input  logic                          open,
	output logic                          record_act,
	output logic                          record_pre,
	output logic                          load,
	output logic [2:0]                    load_value,
	input  logic                          expired,
	output mc_pkg::cmd_e                  cmd,
	output logic [mc_pkg::BANK_BITS-1:0]  bank,
	output logic [mc_pkg::ROW_BITS-1:0]   addr,
	output logic                          cs_n,
	output logic                          issue_wr,
	output logic                          issue_rd
);
	import mc_pkg::*;

	// Entry cycle and expiry cycle of the wait state already cover two cycles of the gap
	localparam logic [2:0] RCD_LOAD = (T_RCD > 2) ? 3'(T_RCD - 2) : 3'd0;
	localparam logic [2:0] RP_LOAD  = (T_RP > 2) ? 3'(T_RP - 2) : 3'd0;

	sched_state_e         state;
	sched_state_e         state_next;
	cmd_e                 cmd_next;
	logic [ROW_BITS-1:0]  addr_next;
	logic [ROW_BITS-1:0]  head_row;
	logic [BANK_BITS-1:0] head_bank;
	logic [COL_BITS-1:0]  head_col;

	assign head_row  = rq.head_addr[ADDR_BITS-1 -: ROW_BITS];  // Top field
	assign head_bank = rq.head_addr[COL_BITS +: BANK_BITS];
	assign head_col  = rq.head_addr[COL_BITS-1:0];

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE: begin
				if (rq.head_valid) begin
					if (hit)
						state_next = S_ISSUE;  // Row already open
					else if (open)
						state_next = S_PRE;    // Other row open, close it first
					else
						state_next = S_ACT;    // Bank closed
				end
			end
			S_PRE:      state_next = S_WAIT_RP;
			S_WAIT_RP:  state_next = expired ? S_ACT : S_WAIT_RP;
			S_ACT:      state_next = S_WAIT_RCD;
			S_WAIT_RCD: state_next = expired ? S_ISSUE : S_WAIT_RCD;
			S_ISSUE:    state_next = S_IDLE;  // Head drops on this edge
			default:    state_next = S_IDLE;
		endcase
	end

	// Command of the next state, registered so it lines up with that state
	always_comb begin
		cmd_next  = CMD_NOP;
		addr_next = '0;
		case (state_next)
			S_PRE: begin
				cmd_next = CMD_PRE;
			end
			S_ACT: begin
				cmd_next  = CMD_ACT;
				addr_next = head_row;  // Row on ACT
			end
			S_ISSUE: begin
				cmd_next  = rq.head_write ? CMD_WR : CMD_RD;
				addr_next = ROW_BITS'(head_col);  // Column on WR/RD
			end
			default: begin
				cmd_next = CMD_NOP;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			cmd   <= CMD_NOP;
			cs_n  <= 1'b1;
			bank  <= '0;
			addr  <= '0;
		end else begin
			state <= state_next;
			cmd   <= cmd_next;
			cs_n  <= (cmd_next == CMD_NOP);  // Select only with a real command
			bank  <= (cmd_next == CMD_NOP) ? '0 : head_bank;
			addr  <= addr_next;
		end
	end

	assign load       = (state == S_PRE) || (state == S_ACT);  // Count starts in wait state
	assign load_value = (state == S_PRE) ? RP_LOAD : RCD_LOAD;
	assign record_pre = (state == S_PRE);
	assign record_act = (state == S_ACT);
	assign issue_wr   = (state == S_ISSUE) && rq.head_write;
	assign issue_rd   = (state == S_ISSUE) && !rq.head_write;
	assign rq.pop     = (state == S_ISSUE);  // Same cycle as WR/RD

endmodule

// File: hdl/gap_timer.sv
`timescale 1ns/10ps
module gap_timer (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       load,
	input  logic [2:0] load_value,
	output logic       expired
);

	logic [2:0] count;  // Remaining gap cycles

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
		end else if (load) begin
			count <= load_value;  // Restart, even mid-count
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// Stays high until the next load
	assign expired = (count == '0);

endmodule

// File: hdl/row_tracker.sv
`timescale 1ns/10ps
module row_tracker (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [mc_pkg::ADDR_BITS-1:0]  head_addr,
	input  logic                          record_act,
	input  logic                          record_pre,
	output logic                          hit,
	output logic                          open
);
	import mc_pkg::*;

	localparam int NUM_BANKS = 1 << BANK_BITS;

	logic [NUM_BANKS-1:0] open_q;              // Row open per bank
	logic [ROW_BITS-1:0]  row_q [NUM_BANKS];   // Open row per bank
	logic [BANK_BITS-1:0] head_bank;
	logic [ROW_BITS-1:0]  head_row;

	assign head_row  = head_addr[ADDR_BITS-1 -: ROW_BITS];
	assign head_bank = head_addr[COL_BITS +: BANK_BITS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			open_q <= '0;  // All banks closed
		end else if (record_act) begin
			open_q[head_bank] <= 1'b1;
		end else if (record_pre) begin
			open_q[head_bank] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (record_act)
			row_q[head_bank] <= head_row;  // Only meaningful while open
	end

	assign open = open_q[head_bank];
	assign hit  = open_q[head_bank] && (row_q[head_bank] == head_row);

endmodule

// File: hdl/dq_path.sv
`timescale 1ns/10ps
module dq_path #(
	parameter int DATA_WIDTH = 16,
	parameter int T_CL       = 4
) (
	input  logic                  clk,
	input  logic                  rst_n,
	req_if.data_side              rq,
	input  logic                  issue_wr,
	input  logic                  issue_rd,
	output logic [DATA_WIDTH-1:0] dq_out,
	output logic                  dq_oe,
	input  logic [DATA_WIDTH-1:0] dq_in,
	output logic                  write_done,
	output logic                  read_done,
	output logic [DATA_WIDTH-1:0] data_out
);

	logic [T_CL-1:0] rd_pipe;  // One marker per read in flight

	// Write data goes out with CMD_WR
	assign dq_oe      = issue_wr;
	assign dq_out     = issue_wr ? rq.head_data : '0;  // Quiet bus otherwise
	assign write_done = issue_wr;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_pipe   <= '0;
			read_done <= 1'b0;
		end else begin
			rd_pipe[0] <= issue_rd;
			for (int i = 1; i < T_CL; i++) begin
				rd_pipe[i] <= rd_pipe[i-1];
			end
			read_done <= rd_pipe[T_CL-1];  // One edge after data on dq_in
		end
	end

	// Marker reaches the end in the cycle the memory drives dq_in
	always_ff @(posedge clk) begin
		if (rd_pipe[T_CL-1])
			data_out <= dq_in;
	end

endmodule

// File: hdl/mem_ctrl_top.sv
`timescale 1ns/10ps
module mem_ctrl_top #(
	parameter int DATA_WIDTH  = 16,
	parameter int QUEUE_DEPTH = 4,
	parameter int T_RCD       = 3,
	parameter int T_RP        = 2,
	parameter int T_CL        = 4
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          in_valid,
	input  logic                          in_request_type,
	input  logic [mc_pkg::ADDR_BITS-1:0]  in_request_address,
	input  logic [DATA_WIDTH-1:0]         in_request_data,
	output logic                          out_busy,
	output logic                          write_done,
	output logic                          read_done,
	output logic [DATA_WIDTH-1:0]         data_out,
	output logic                          cs_n,
	output mc_pkg::cmd_e                  cmd,
	output logic [mc_pkg::BANK_BITS-1:0]  bank,
	output logic [mc_pkg::ROW_BITS-1:0]   addr,
	output logic [DATA_WIDTH-1:0]         dq_out,
	output logic                          dq_oe,
	input  logic [DATA_WIDTH-1:0]         dq_in
);

	logic       row_hit;     // Head row open in its bank
	logic       row_open;    // Head bank has some row open
	logic       record_act;
	logic       record_pre;
	logic       tmr_load;
	logic [2:0] tmr_value;
	logic       tmr_expired;
	logic       issue_wr;
	logic       issue_rd;

	req_if #(.DATA_WIDTH(DATA_WIDTH)) rq ();  // Head request bundle

	req_queue #(.DATA_WIDTH(DATA_WIDTH), .QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
		.clk, .rst_n, .in_valid, .in_request_type, .in_request_address,
		.in_request_data, .out_busy, .rq(rq.queue_side)
	);

	cmd_fsm #(.T_RCD(T_RCD), .T_RP(T_RP)) u_fsm (
		.clk, .rst_n, .rq(rq.sched_side), .hit(row_hit), .open(row_open),
		.record_act, .record_pre, .load(tmr_load), .load_value(tmr_value),
		.expired(tmr_expired), .cmd, .bank, .addr, .cs_n, .issue_wr, .issue_rd
	);

	gap_timer u_timer (
		.clk, .rst_n, .load(tmr_load), .load_value(tmr_value), .expired(tmr_expired)
	);

	row_tracker u_rows (
		.clk, .rst_n, .head_addr(rq.head_addr), .record_act, .record_pre,
		.hit(row_hit), .open(row_open)
	);

	dq_path #(.DATA_WIDTH(DATA_WIDTH), .T_CL(T_CL)) u_dq (
		.clk, .rst_n, .rq(rq.data_side), .issue_wr, .issue_rd, .dq_out, .dq_oe,
		.dq_in, .write_done, .read_done, .data_out
	);

endmodule

// File: verif/mem_ctrl_assert.sv
`timescale 1ns/10ps
module mem_ctrl_assert #(
	parameter int T_RCD = 3,
	parameter int T_RP  = 2
) (
	input logic         clk,
	input logic         rst_n,
	input mc_pkg::cmd_e cmd,
	input logic         dq_oe
);
	import mc_pkg::*;

	logic [3:0] since_act;  // Cycles since last ACT, saturating
	logic [3:0] since_pre;  // Cycles since last PRE, saturating

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			since_act <= '1;
			since_pre <= '1;
		end else begin
			since_act <= (cmd == CMD_ACT) ? 4'd1 : (since_act == 4'hf) ? since_act : since_act + 4'd1;
			since_pre <= (cmd == CMD_PRE) ? 4'd1 : (since_pre == 4'hf) ? since_pre : since_pre + 4'd1;
		end
	end

	a_rcd: assert property (@(posedge clk) disable iff (!rst_n)
		(cmd == CMD_WR || cmd == CMD_RD) |-> int'(since_act) >= T_RCD)
		else $error("column command issued too soon after ACT");
	a_rp: assert property (@(posedge clk) disable iff (!rst_n)
		(cmd == CMD_ACT) |-> int'(since_pre) >= T_RP)
		else $error("ACT issued too soon after PRE");
	a_oe: assert property (@(posedge clk) disable iff (!rst_n) dq_oe |-> cmd == CMD_WR)
		else $error("dq_oe high without CMD_WR");

endmodule

// Command bus and DQ enable both live at the top level
bind mem_ctrl_top mem_ctrl_assert #(.T_RCD(T_RCD), .T_RP(T_RP)) u_assert (
	.clk, .rst_n, .cmd, .dq_oe
);

// File: verif/mem_ctrl_tb.sv
`timescale 1ns/10ps
module mem_ctrl_tb;
	import mc_pkg::*;

	localparam int DATA_WIDTH = 16;
	localparam int QUEUE_DEPTH = 4;
	localparam int T_RCD = 3;
	localparam int T_RP = 2;
	localparam int T_CL = 4;  // Memory model latency
	localparam int N_TBL = 10;
	localparam int N_RAND = 20;
	localparam int N_REQ = N_TBL + QUEUE_DEPTH + 2 + N_RAND;
	localparam logic [1:0] CL_HIT = 2'd0, CL_CLOSED = 2'd1, CL_CONFLICT = 2'd2, CL_ANY = 2'd3;

	// Type, address {row, bank, col}, write data, expected command class
	localparam logic [34:0] STIM [N_TBL] = '{
		{1'b1, 16'h0101, 16'h1111, CL_CLOSED},
		{1'b1, 16'h0102, 16'h2222, CL_HIT},
		{1'b0, 16'h0101, 16'h0000, CL_HIT},
		{1'b0, 16'h0145, 16'h0000, CL_CLOSED},    // Never written
		{1'b1, 16'h0201, 16'h3333, CL_CONFLICT},
		{1'b0, 16'h0102, 16'h0000, CL_CONFLICT},
		{1'b0, 16'h0201, 16'h0000, CL_CONFLICT},
		{1'b1, 16'h0245, 16'h4444, CL_CONFLICT},
		{1'b0, 16'h0245, 16'h0000, CL_HIT},
		{1'b0, 16'h0145, 16'h0000, CL_CONFLICT}
	};

	logic clk, rst_n, in_valid, in_request_type;
	logic [ADDR_BITS-1:0] in_request_address;
	logic [DATA_WIDTH-1:0] in_request_data, data_out, dq_out, dq_in;
	logic out_busy, write_done, read_done, cs_n, dq_oe;
	cmd_e cmd;
	logic [BANK_BITS-1:0] bank;
	logic [ROW_BITS-1:0] addr;

	logic [DATA_WIDTH-1:0] mem [1 << ADDR_BITS];      // Memory model array
	logic [DATA_WIDTH-1:0] ref_mem [1 << ADDR_BITS];  // Predicted contents
	logic [ROW_BITS-1:0] open_row [1 << BANK_BITS];   // Rows opened in the model
	logic [DATA_WIDTH-1:0] rd_stage [T_CL];           // Read latency line
	logic [DATA_WIDTH-1:0] exp_q [$];                 // Read data predictions
	logic [1:0] cls_q [$];                            // Expected class per request
	int rd_cyc_q [$];
	int errors = 0, cyc = 0, n_act = 0, n_pre = 0;
	int acc_wr = 0, acc_rd = 0, done_wr = 0, done_rd = 0;
	int rd_t;
	logic [1:0] cls;
	logic busy_seen = 1'b0;
	logic [31:0] seed = 32'hba96;

	mem_ctrl_top #(.DATA_WIDTH(DATA_WIDTH), .QUEUE_DEPTH(QUEUE_DEPTH), .T_RCD(T_RCD),
		.T_RP(T_RP), .T_CL(T_CL)) u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		#(N_REQ * (T_RP + T_RCD + T_CL + 8) * 40 + 200 * 40);
		$display("watchdog expired before all requests completed");
		$display("sim failed");
		$finish;
	end

	function automatic logic [31:0] next_rand(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Memory model samples the bus at the edge and drives dq_in 2 ns later
	always @(posedge clk) begin
		for (int i = T_CL - 1; i > 0; i--)
			rd_stage[i] = rd_stage[i-1];
		rd_stage[0] = '0;
		if (cmd == CMD_ACT)
			open_row[bank] = addr;
		if (cmd == CMD_WR && dq_oe)
			mem[{open_row[bank], bank, addr[COL_BITS-1:0]}] = dq_out;
		if (cmd == CMD_RD)
			rd_stage[0] = mem[{open_row[bank], bank, addr[COL_BITS-1:0]}];
		#2 dq_in = rd_stage[T_CL-1];
	end

	// Scoreboard on the command bus and done pulses
	always @(posedge clk) begin
		if (rst_n) begin
			cyc++;
			if (out_busy)
				busy_seen = 1'b1;
			assert (cs_n == (cmd == CMD_NOP)) else begin
				$display("FAIL cs_n got %h with cmd %h", cs_n, cmd);
				errors++;
			end
			assert (write_done == (cmd == CMD_WR)) else begin
				$display("FAIL write_done got %h with cmd %h", write_done, cmd);
				errors++;
			end
			if (cmd == CMD_ACT)
				n_act++;
			if (cmd == CMD_PRE)
				n_pre++;
			if (cmd == CMD_WR || cmd == CMD_RD) begin
				cls = cls_q.pop_front();
				if (cls != CL_ANY) begin
					assert (n_act == (cls == CL_HIT ? 0 : 1)
						&& n_pre == (cls == CL_CONFLICT ? 1 : 0))
					else begin
						$display("FAIL cmd class exp %h, act %h pre %h", cls, n_act, n_pre);
						errors++;
					end
				end
				n_act = 0;
				n_pre = 0;
				if (cmd == CMD_RD)
					rd_cyc_q.push_back(cyc);
			end
			if (write_done)
				done_wr++;
			if (read_done) begin
				done_rd++;
				assert (rd_cyc_q.size() > 0 && exp_q.size() > 0) else begin
					$display("read_done pulsed with no read outstanding");
					errors++;
				end
				if (rd_cyc_q.size() > 0 && exp_q.size() > 0) begin
					rd_t = rd_cyc_q.pop_front();
					assert (cyc - rd_t == T_CL + 1) else begin
						$display("FAIL read_done latency got %h exp %h", cyc - rd_t, T_CL + 1);
						errors++;
					end
					assert (data_out == exp_q[0]) else begin
						$display("FAIL data_out got %h exp %h", data_out, exp_q[0]);
						errors++;
					end
					void'(exp_q.pop_front());
				end
			end
		end
	end

	// Holds the strobe until the queue takes it
	task automatic send(input logic wr, input logic [ADDR_BITS-1:0] a,
		input logic [DATA_WIDTH-1:0] d, input logic [1:0] c);
		logic taken;
		in_valid = 1'b1;
		in_request_type = wr;
		in_request_address = a;
		in_request_data = d;
		do begin
			@(negedge clk);
			taken = !out_busy;  // Stable between edges
			@(posedge clk);
			#2;
		end while (!taken);
		cls_q.push_back(c);
		if (wr) begin
			ref_mem[a] = d;
			acc_wr++;
		end else begin
			exp_q.push_back(ref_mem[a]);
			acc_rd++;
		end
	endtask

	task automatic drain();
		in_valid = 1'b0;
		while (done_wr != acc_wr || done_rd != acc_rd)
			@(negedge clk);  // Counts settle at the rising edge
		@(posedge clk);
		#2;
	endtask

	initial begin
		in_valid = 1'b0;
		in_request_type = 1'b0;
		in_request_address = '0;
		in_request_data = '0;
		dq_in = '0;
		rst_n = 1'b0;
		for (int i = 0; i < (1 << ADDR_BITS); i++) begin
			mem[i] = '0;
			ref_mem[i] = '0;
		end
		for (int i = 0; i < T_CL; i++)
			rd_stage[i] = '0;
		repeat (4) @(posedge clk);
		#2 rst_n = 1'b1;
		@(posedge clk);
		#2;
		assert (cs_n && cmd == CMD_NOP && !out_busy && !write_done && !read_done) else begin
			$display("FAIL idle outputs cs_n %h cmd %h out_busy %h write_done %h read_done %h",
				cs_n, cmd, out_busy, write_done, read_done);
			errors++;
		end
		for (int i = 0; i < N_TBL; i++)  // Directed row policy table
			send(STIM[i][34], STIM[i][33:18], STIM[i][17:2], STIM[i][1:0]);
		drain();
		busy_seen = 1'b0;
		for (int i = 0; i < QUEUE_DEPTH + 2; i++)  // Burst past queue depth
			send(1'b1, {8'h05, 2'd2, 6'(i)}, 16'(16'hb000 + i), i == 0 ? CL_CLOSED : CL_HIT);
		drain();
		assert (busy_seen) else begin
			$display("out_busy never rose during the burst");
			errors++;
		end
		for (int i = 0; i < N_RAND; i++) begin  // Small address space for hits
			seed = next_rand(seed);
			send(seed[12], {6'd0, seed[9:8], seed[7:6], 3'd0, seed[2:0]}, seed[31:16], CL_ANY);
		end
		drain();
		repeat (T_CL + 2) @(posedge clk);
		$display("checks finished with %0d errors", errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: verilog.f
hdl/mc_pkg.sv
hdl/req_if.sv
hdl/req_queue.sv
hdl/cmd_fsm.sv
hdl/gap_timer.sv
hdl/row_tracker.sv
hdl/dq_path.sv
hdl/mem_ctrl_top.sv
verif/mem_ctrl_assert.sv
verif/mem_ctrl_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module mem_ctrl_tb
./obj_dir/Vmem_ctrl_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "sim failed" sim.log; then
	exit 1
fi
grep -q "sim passed" sim.log
